// File: Bender.yml
package:
  name: dsp_readout

sources:
  - common/readout_pkg.sv
  - source/shot_sequencer.sv
  - readout_channel/mix_accumulator.sv
  - readout_channel/acc_buffer.sv
  - source/acc_readout.sv
  - source/dsp_readout.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/dsp_readout_props.sv
      - testbench/tb_dsp_readout.sv

// File: common/readout_pkg.sv
package readout_pkg;

	// adc sample and lo component widths
	localparam int ADC_W = 16;
	localparam int LO_W = 16;

	// full product of one sample and one lo component
	localparam int PROD_W = 32;

	// room for 255 summed products
	localparam int ACC_W = 40;

	// stored width of each shifted sum
	localparam int ACC_OUT_W = 32;

	// accumulation buffer, per channel
	localparam int ACC_DEPTH = 16;
	localparam int ACC_ADDR_W = 4;

	// number of readout channels
	localparam int NCHAN = 2;

	// run configuration field widths
	localparam int NSHOT_W = 16;
	localparam int GATE_LEN_W = 8;
	localparam int SHIFT_W = 4;

	// idle cycles after each gate before the next shot
	localparam int DRAIN_CYCLES = 3;

	// complex lo value fed to one channel
	typedef struct packed {
		logic signed [LO_W-1:0] lo_cos;
		logic signed [LO_W-1:0] lo_sin;
	} lo_t;

	// one stored shot result, i and q
	typedef struct packed {
		logic signed [ACC_OUT_W-1:0] acc_x;
		logic signed [ACC_OUT_W-1:0] acc_y;
	} acc_entry_t;

	// experiment settings from the host
	// nshot of zero means run until reset
	typedef struct packed {
		logic [NSHOT_W-1:0] nshot;
		logic [GATE_LEN_W-1:0] gate_len;
		logic [SHIFT_W-1:0] shift;
	} run_cfg_t;

endpackage

// File: compile.f
common/readout_pkg.sv
source/shot_sequencer.sv
readout_channel/mix_accumulator.sv
readout_channel/acc_buffer.sv
source/acc_readout.sv
source/dsp_readout.sv
testbench/tb_clock.sv
testbench/dsp_readout_props.sv
testbench/tb_dsp_readout.sv

// File: readout_channel/acc_buffer.sv
`timescale 1ns/1ps

module acc_buffer (
	input logic clk,
	input logic rst_n,
	input logic acc_clear,
	input logic acc_stb,
	input readout_pkg::acc_entry_t acc_in,
	input logic [readout_pkg::ACC_ADDR_W-1:0] rd_addr,
	output readout_pkg::acc_entry_t rd_entry,
	output logic [readout_pkg::ACC_ADDR_W-1:0] wr_addr
);
	import readout_pkg::*;

	// one result per shot
	acc_entry_t mem [ACC_DEPTH];

	// write strobe, one cycle late, steps the address
	logic wr_stb_d;

	// address sits on the final entry
	logic wr_last;

	assign wr_last = (wr_addr == ACC_ADDR_W'(ACC_DEPTH - 1));

	always_ff @(posedge clk) begin
		if (acc_stb)
			mem[wr_addr] <= acc_in;
	end

	// asynchronous read for the host port
	assign rd_entry = mem[rd_addr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wr_stb_d <= 1'b0;
		else
			wr_stb_d <= acc_stb;
	end

	// clear wins over a pending step
	// once locked, later shots land on the last entry again
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wr_addr <= '0;
		else if (acc_clear)
			wr_addr <= '0;
		else if (wr_stb_d && !wr_last)
			wr_addr <= wr_addr + 1'b1;
	end

endmodule

// File: readout_channel/mix_accumulator.sv
`timescale 1ns/1ps

module mix_accumulator (
	input logic clk,
	input logic rst_n,
	input logic gate,
	input logic signed [readout_pkg::ADC_W-1:0] adc,
	input readout_pkg::lo_t lo,
	input logic [readout_pkg::SHIFT_W-1:0] shift,
	output logic acc_stb,
	output readout_pkg::acc_entry_t acc_out
);
	import readout_pkg::*;

	// registered i and q products
	logic signed [PROD_W-1:0] prod_x;
	logic signed [PROD_W-1:0] prod_y;

	// gate lined up with the products, and one more stage for the edge
	logic gate_d;
	logic gate_dd;

	// running sums over the gate window
	logic signed [ACC_W-1:0] acc_x;
	logic signed [ACC_W-1:0] acc_y;

	// sums after the arithmetic shift
	logic signed [ACC_W-1:0] shifted_x;
	logic signed [ACC_W-1:0] shifted_y;

	// complex mix, one stage
	always_ff @(posedge clk) begin
		prod_x <= adc * lo.lo_cos;
		prod_y <= adc * lo.lo_sin;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gate_d <= 1'b0;
			gate_dd <= 1'b0;
		end else begin
			gate_d <= gate;
			gate_dd <= gate_d;
		end
	end

	// first gated product restarts the sum
	always_ff @(posedge clk) begin
		if (gate_d) begin
			if (!gate_dd) begin
				acc_x <= prod_x;
				acc_y <= prod_y;
			end else begin
				acc_x <= acc_x + prod_x;
				acc_y <= acc_y + prod_y;
			end
		end
	end

	// sums are final once the delayed gate has dropped
	assign acc_stb = gate_dd & ~gate_d;

	assign shifted_x = acc_x >>> shift;
	assign shifted_y = acc_y >>> shift;

	// keep the low bits only
	assign acc_out.acc_x = shifted_x[ACC_OUT_W-1:0];
	assign acc_out.acc_y = shifted_y[ACC_OUT_W-1:0];

endmodule

// File: source/acc_readout.sv
`timescale 1ns/1ps

module acc_readout (
	input logic clk,
	input logic rst_n,
	input logic rd_stb,
	input logic rd_chan,
	input logic [readout_pkg::ACC_ADDR_W-1:0] rd_addr,
	input readout_pkg::acc_entry_t chan_entry [readout_pkg::NCHAN],
	output logic [readout_pkg::ACC_ADDR_W-1:0] buf_addr,
	output logic rd_valid,
	output readout_pkg::acc_entry_t rd_data
);

	// both buffers see the same address
	// the channel is picked on their outputs
	assign buf_addr = rd_addr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_stb;
	end

	// data holds until the next request
	always_ff @(posedge clk) begin
		if (rd_stb)
			rd_data <= chan_entry[rd_chan];
	end

endmodule

// File: source/dsp_readout.sv
`timescale 1ns/1ps

module dsp_readout (
	input logic clk,
	input logic rst_n,
	input logic stb_start,
	input logic acc_clear,
	input readout_pkg::run_cfg_t cfg,
	input logic signed [readout_pkg::ADC_W-1:0] adc [readout_pkg::NCHAN],
	input readout_pkg::lo_t lo [readout_pkg::NCHAN],
	input logic rd_stb,
	input logic rd_chan,
	input logic [readout_pkg::ACC_ADDR_W-1:0] rd_addr,
	output logic rd_valid,
	output readout_pkg::acc_entry_t rd_data,
	output logic [readout_pkg::NSHOT_W-1:0] shot_count,
	output logic last_shot_done,
	output logic busy,
	output logic [readout_pkg::ACC_ADDR_W-1:0] wr_addr [readout_pkg::NCHAN]
);
	import readout_pkg::*;

	// gate window, common to all channels
	logic gate;

	// per-channel result strobe and value
	logic acc_stb [NCHAN];
	acc_entry_t acc_entry [NCHAN];

	// buffer outputs toward the read port
	acc_entry_t chan_entry [NCHAN];
	logic [ACC_ADDR_W-1:0] buf_addr;

	shot_sequencer seq0 (
		.clk(clk),
		.rst_n(rst_n),
		.stb_start(stb_start),
		.cfg(cfg),
		.gate(gate),
		.shot_count(shot_count),
		.last_shot_done(last_shot_done),
		.busy(busy)
	);

	// channel n mixes adc[n] with lo[n]
	for (genvar i = 0; i < NCHAN; i++) begin : chan
		mix_accumulator mix (
			.clk(clk),
			.rst_n(rst_n),
			.gate(gate),
			.adc(adc[i]),
			.lo(lo[i]),
			.shift(cfg.shift),
			.acc_stb(acc_stb[i]),
			.acc_out(acc_entry[i])
		);

		acc_buffer accbuf (
			.clk(clk),
			.rst_n(rst_n),
			.acc_clear(acc_clear),
			.acc_stb(acc_stb[i]),
			.acc_in(acc_entry[i]),
			.rd_addr(buf_addr),
			.rd_entry(chan_entry[i]),
			.wr_addr(wr_addr[i])
		);
	end

	acc_readout rdout0 (
		.clk(clk),
		.rst_n(rst_n),
		.rd_stb(rd_stb),
		.rd_chan(rd_chan),
		.rd_addr(rd_addr),
		.chan_entry(chan_entry),
		.buf_addr(buf_addr),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

endmodule

// File: source/shot_sequencer.sv
`timescale 1ns/1ps

module shot_sequencer (
	input logic clk,
	input logic rst_n,
	input logic stb_start,
	input readout_pkg::run_cfg_t cfg,
	output logic gate,
	output logic [readout_pkg::NSHOT_W-1:0] shot_count,
	output logic last_shot_done,
	output logic busy
);
	import readout_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		START,
		RUN,
		DRAIN,
		MORESHOT,
		SHOTADD,
		DONE
	} seq_state_t;

	seq_state_t state;
	seq_state_t next_state;

	// settings held for the whole run
	run_cfg_t cfg_r;

	// shared down-counter, times the gate window and then the drain
	logic [GATE_LEN_W-1:0] cnt;
	logic cnt_zero;

	// another shot is due
	logic more_shots;

	assign cnt_zero = (cnt == '0);

	// shot_count already holds the finished shot when MORESHOT decides
	assign more_shots = (cfg_r.nshot == '0) || (shot_count != cfg_r.nshot);

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (stb_start)
					next_state = START;
			end
			START: next_state = RUN;
			RUN: begin
				if (cnt_zero)
					next_state = DRAIN;
			end
			DRAIN: begin
				if (cnt_zero)
					next_state = MORESHOT;
			end
			MORESHOT: next_state = more_shots ? SHOTADD : DONE;
			SHOTADD: next_state = START;
			DONE: next_state = IDLE;
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= next_state;
	end

	// cfg follows the inputs while idle, so the start edge captures it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cfg_r <= '0;
		else if (state == IDLE)
			cfg_r <= cfg;
	end

	// RUN lasts gate_len cycles, DRAIN lasts DRAIN_CYCLES
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cnt <= '0;
		else if (state == START)
			cnt <= cfg_r.gate_len - 1'b1;
		else if (state == RUN && cnt_zero)
			cnt <= GATE_LEN_W'(DRAIN_CYCLES - 1);
		else if (!cnt_zero)
			cnt <= cnt - 1'b1;
	end

	// cleared on start, bumped as each gate closes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			shot_count <= '0;
		else if (state == IDLE && stb_start)
			shot_count <= '0;
		else if (state == RUN && cnt_zero)
			shot_count <= shot_count + 1'b1;
	end

	assign gate = (state == RUN);
	assign last_shot_done = (state == DONE);
	assign busy = (state != IDLE);

endmodule

// File: testbench/dsp_readout_props.sv
`timescale 1ns/1ps

module dsp_readout_props (
	input logic clk,
	input logic rst_n,
	input logic acc_clear,
	input logic rd_stb,
	input logic rd_valid,
	input logic last_shot_done,
	input logic [readout_pkg::ACC_ADDR_W-1:0] wr_addr [readout_pkg::NCHAN]
);
	import readout_pkg::*;

	// read data comes exactly one cycle after the request
	rd_valid_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
		rd_stb |=> rd_valid)
		else $error("rd_valid missing one cycle after rd_stb");

	// and never without a request
	rd_valid_needs_stb: assert property (@(posedge clk) disable iff (!rst_n)
		rd_valid |-> $past(rd_stb))
		else $error("rd_valid without a preceding rd_stb");

	// done is a single-cycle strobe
	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		last_shot_done |=> !last_shot_done)
		else $error("last_shot_done held for two cycles");

	// write address only moves backwards on a clear
	for (genvar i = 0; i < NCHAN; i++) begin : wr_chk
		wr_addr_no_step_back: assert property (@(posedge clk) disable iff (!rst_n)
			(wr_addr[i] < $past(wr_addr[i])) |-> $past(acc_clear))
			else $error("wr_addr went back without acc_clear on channel %0d", i);
	end

endmodule

bind dsp_readout dsp_readout_props props0 (
	.clk(clk),
	.rst_n(rst_n),
	.acc_clear(acc_clear),
	.rd_stb(rd_stb),
	.rd_valid(rd_valid),
	.last_shot_done(last_shot_done),
	.wr_addr(wr_addr)
);

// File: testbench/readout_stimulus.txt
# name nshot gate_len shift adc0 adc1 lo0_cos lo0_sin lo1_cos lo1_sin wr0 wr1 x0 y0 x1 y1 shots
# decimal; x and y are each channel's expected entry at every written address
# nshot 0 runs continuously, shots is then the least count after 20 shot periods

single_shot 1 10 0 100 200 300 400 1000 2000 1 1 300000 400000 2000000 4000000 1
several_shots 5 8 2 1000 -1000 1234 -4321 32767 16384 5 5 2468000 -8642000 -65534000 -32768000 5
signed_shift 1 7 5 -333 777 -1001 2003 -12345 -7 1 1 72916 -145907 -2098265 -1190 1
lock_last 20 4 1 -2000 1500 500 -600 -700 800 15 15 -2000000 2400000 -2100000 2400000 20
continuous 0 3 0 11 -13 17 19 23 -29 15 15 561 627 -897 1131 20
clear_select 2 6 3 -7 5 9000 -9000 -3 12000 2 2 -47250 47250 -12 45000 2
clear_rerun 3 10 0 100 200 300 400 1000 2000 3 3 300000 400000 2000000 4000000 3

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	// 100 ns period
	localparam int HALF_PERIOD = 50;

	// power-on reset length in clock cycles
	localparam int RESET_CYCLES = 5;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// release just after an edge, like the other inputs
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

// File: testbench/tb_dsp_readout.sv
`timescale 1ns/1ps

module tb_dsp_readout;
	import readout_pkg::*;

	localparam int MAX_TESTS = 16;
	// start, moreshot and shotadd around gate and drain
	localparam int SHOT_EXTRA = DRAIN_CYCLES + 3;
	// shots watched in continuous mode
	localparam int CONT_SHOTS = 20;
	localparam string STIM_PATH = "testbench/readout_stimulus.txt";

	logic clk;
	logic por_rst_n;
	logic run_rst;
	logic rst_n;
	logic stb_start;
	logic acc_clear;
	run_cfg_t cfg;
	logic signed [ADC_W-1:0] adc [NCHAN];
	lo_t lo [NCHAN];
	logic rd_stb;
	logic rd_chan;
	logic [ACC_ADDR_W-1:0] rd_addr;
	logic rd_valid;
	acc_entry_t rd_data;
	logic [NSHOT_W-1:0] shot_count;
	logic last_shot_done;
	logic busy;
	logic [ACC_ADDR_W-1:0] wr_addr [NCHAN];

	// raw stimulus lines parsed again per test
	string t_line [MAX_TESTS];
	int ntests = 0;
	string test_name = "none";
	int error_count = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	// power-on reset or a reset forced mid-run
	assign rst_n = por_rst_n & ~run_rst;

	tb_clock clkgen0 (
		.clk(clk),
		.rst_n(por_rst_n)
	);

	dsp_readout dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.stb_start(stb_start),
		.acc_clear(acc_clear),
		.cfg(cfg),
		.adc(adc),
		.lo(lo),
		.rd_stb(rd_stb),
		.rd_chan(rd_chan),
		.rd_addr(rd_addr),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.shot_count(shot_count),
		.last_shot_done(last_shot_done),
		.busy(busy),
		.wr_addr(wr_addr)
	);

	task automatic fail_run;
		$display("Test failed");
		$fatal(1);
	endtask

	// one clock then 1 ns for driving and sampling
	task automatic step;
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string what, input longint expected, input longint actual);
		assert (expected == actual) else begin
			$display("MISMATCH %s %s expected %0d actual %0d", test_name, what, expected, actual);
			error_count++;
			fail_run();
		end
	endtask

	task automatic load_stimulus;
		int fd;
		int code;
		int nshot;
		int gate_len;
		int shots;
		string line;
		string name;
		fd = $fopen(STIM_PATH, "r");
		if (fd == 0) begin
			$display("cannot open stimulus file %s", STIM_PATH);
			fail_run();
		end
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			// skip blanks and comment lines
			if (code > 1 && line[0] != "#") begin
				code = $sscanf(line, "%s %d %d", name, nshot, gate_len);
				if (code != 3 || ntests == MAX_TESTS) begin
					$display("bad or surplus stimulus line: %s", line);
					fail_run();
				end
				t_line[ntests] = line;
				ntests++;
				shots = (nshot == 0) ? CONT_SHOTS : nshot;
				cycle_limit += shots * (gate_len + SHOT_EXTRA) + NCHAN * ACC_DEPTH + 20;
			end
		end
		$fclose(fd);
		// reset cycles on top and a factor of two margin
		cycle_limit = 2 * (cycle_limit + 20);
	endtask

	task automatic read_entry(input int chan, input int addr, input int ex, input int ey);
		rd_stb = 1'b1;
		rd_chan = chan[0];
		rd_addr = ACC_ADDR_W'(addr);
		step();
		rd_stb = 1'b0;
		assert (rd_valid) else begin
			$display("no rd_valid one cycle after read of ch%0d[%0d] in %s", chan, addr, test_name);
			error_count++;
			fail_run();
		end
		check_value($sformatf("ch%0d[%0d].acc_x", chan, addr), ex, rd_data.acc_x);
		check_value($sformatf("ch%0d[%0d].acc_y", chan, addr), ey, rd_data.acc_y);
	endtask

	task automatic run_test(input string line);
		string name;
		int code;
		int nshot;
		int gate_len;
		int shift;
		int period;
		int n_read;
		int half_count;
		int adc_v [NCHAN];
		int lo_c [NCHAN];
		int lo_s [NCHAN];
		int exp_wr [NCHAN];
		int exp_x [NCHAN];
		int exp_y [NCHAN];
		int exp_shots;
		code = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
			name, nshot, gate_len, shift, adc_v[0], adc_v[1], lo_c[0], lo_s[0],
			lo_c[1], lo_s[1], exp_wr[0], exp_wr[1], exp_x[0], exp_y[0],
			exp_x[1], exp_y[1], exp_shots);
		if (code != 17) begin
			$display("stimulus line has %0d of 17 fields: %s", code, line);
			fail_run();
		end
		test_name = name;
		period = gate_len + SHOT_EXTRA;
		half_count = 0;
		cfg.nshot = NSHOT_W'(nshot);
		cfg.gate_len = GATE_LEN_W'(gate_len);
		cfg.shift = SHIFT_W'(shift);
		// inputs stay fixed for the whole run
		for (int c = 0; c < NCHAN; c++) begin
			adc[c] = ADC_W'(adc_v[c]);
			lo[c].lo_cos = LO_W'(lo_c[c]);
			lo[c].lo_sin = LO_W'(lo_s[c]);
		end
		acc_clear = 1'b1;
		step();
		for (int c = 0; c < NCHAN; c++)
			check_value($sformatf("wr_addr[%0d] after clear", c), 0, wr_addr[c]);
		acc_clear = 1'b0;
		stb_start = 1'b1;
		step();
		stb_start = 1'b0;
		// sequencer has left IDLE on the start strobe
		check_value("busy after start", 1, busy);
		if (nshot != 0) begin
			while (!last_shot_done)
				step();
			check_value("shot_count", exp_shots, shot_count);
		end else begin
			// continuous mode has no done strobe
			for (int k = 0; k < CONT_SHOTS * period; k++) begin
				assert (!last_shot_done) else begin
					$display("last_shot_done seen in continuous mode in %s", test_name);
					error_count++;
					fail_run();
				end
				if (k == (CONT_SHOTS / 2) * period)
					half_count = shot_count;
				step();
			end
			assert (shot_count > half_count && shot_count >= exp_shots) else begin
				$display("MISMATCH %s shot_count expected at least %0d and above %0d actual %0d",
					test_name, exp_shots, half_count, shot_count);
				error_count++;
				fail_run();
			end
		end
		for (int c = 0; c < NCHAN; c++)
			check_value($sformatf("wr_addr[%0d]", c), exp_wr[c], wr_addr[c]);
		// every written slot holds the same shot result
		n_read = (nshot == 0 || nshot > ACC_DEPTH) ? ACC_DEPTH : nshot;
		for (int c = 0; c < NCHAN; c++)
			for (int a = 0; a < n_read; a++)
				read_entry(c, a, exp_x[c], exp_y[c]);
		if (nshot == 0) begin
			run_rst = 1'b1;
			step();
			check_value("busy in reset", 0, busy);
			check_value("shot_count in reset", 0, shot_count);
			run_rst = 1'b0;
			step();
		end
	endtask

	// timeout counter with its limit set once the stimulus is loaded
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("timeout after %0d cycles in %s", cycle_count, test_name);
			fail_run();
		end
	end

	initial begin
		run_rst = 1'b0;
		stb_start = 1'b0;
		acc_clear = 1'b0;
		cfg = '0;
		rd_stb = 1'b0;
		rd_chan = 1'b0;
		rd_addr = '0;
		for (int c = 0; c < NCHAN; c++) begin
			adc[c] = '0;
			lo[c] = '0;
		end
		load_stimulus();
		wait (por_rst_n === 1'b1);
		step();
		for (int t = 0; t < ntests; t++)
			run_test(t_line[t]);
		if (error_count == 0) begin
			$display("Test passed");
			$finish;
		end else
			fail_run();
	end

endmodule
